// ==== hw/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    localparam int SAMPLE_W = 24;   // signed two's complement
    localparam int GAIN_W = 16;     // unsigned gain word
    localparam int GAIN_FRAC = 8;   // 0x0100 is unity
    localparam int NUM_RATE = 5;
    localparam int CH_BITS_MAX = 3; // up to 8 channels

    localparam logic [GAIN_W-1:0] GAIN_RESET = 16'h00ff;

    // one bit per class, bit 0 is 32 kHz
    localparam int unsigned RATE_HZ [NUM_RATE] = '{32000, 44100, 48000, 96000, 192000};

    // address tag, addr[11:8]
    typedef enum logic [3:0] {
        PAGE_VOL      = 4'h0,
        PAGE_NKMD_RST = 4'h4,
        PAGE_DBGOUT   = 4'h5,
        PAGE_DBGIN    = 4'h6,
        PAGE_RATE     = 4'h8,
        PAGE_UDATA    = 4'h9,
        PAGE_CDATA    = 4'ha
    } csr_page_e;

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_LEFT,
        SC_RIGHT
    } scaler_state_e;

    typedef struct packed {
        logic [31:0] lo;
        logic [31:0] hi;
    } rate_win_t;

    // frame period window in clock cycles, nominal -3% .. +3%
    function automatic rate_win_t rate_window(input longint unsigned clk_hz, input int idx);
        rate_win_t w;
        longint unsigned den;
        den = longint'(RATE_HZ[idx]) * 100;
        w.lo = 32'(clk_hz * 97 / den);
        w.hi = 32'(clk_hz * 103 / den);
        return w;
    endfunction

endpackage

`default_nettype wire

// ==== hw/csr.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr #(
    parameter int NUM_CH = 8,
    parameter int NUM_SPDIF_IN = 3
) (
    input  wire clk,
    input  wire rst,

    // host byte bus
    input  wire [11:0] addr_i,
    input  wire ack_i,           // write strobe
    input  wire [7:0] data_i,
    output logic [7:0] data_o,   // one cycle after addr_i

    output logic [NUM_CH*32-1:0] vol_o,   // page 0
    output logic nkmd_rst_o,              // page 4
    input  wire [127:0] nkmd_dbgout_i,    // page 5, read only
    output logic [127:0] nkmd_dbgin_o,    // page 6
    input  wire [NUM_SPDIF_IN*audio_pkg::NUM_RATE-1:0] rate_i,  // page 8
    input  wire [NUM_SPDIF_IN*192-1:0] udata_i,                 // page 9
    input  wire [NUM_SPDIF_IN*192-1:0] cdata_i                  // page a
);
    import audio_pkg::*;

    localparam int DBG_BYTES = 16;
    localparam int VOL_BYTES = NUM_CH * 4;
    localparam int CAP_BYTES = NUM_SPDIF_IN * 24;

    csr_page_e page;
    logic [7:0] offset;
    logic [7:0] rdata;

    assign page = csr_page_e'(addr_i[11:8]);
    assign offset = addr_i[7:0];

    // write side
    always_ff @(posedge clk) begin
        if (rst) begin
            vol_o <= {(NUM_CH * 2){GAIN_RESET}};
            nkmd_rst_o <= 1'b1;   // dsp held in reset until host releases it
            nkmd_dbgin_o <= '0;
        end else if (ack_i) begin
            case (page)
                PAGE_VOL: begin
                    if (int'(offset) < VOL_BYTES) begin
                        vol_o[offset*8 +: 8] <= data_i;
                    end
                end
                PAGE_NKMD_RST: begin
                    if (offset == 8'd0) begin
                        nkmd_rst_o <= data_i[0];
                    end
                end
                PAGE_DBGIN: begin
                    if (int'(offset) < DBG_BYTES) begin
                        nkmd_dbgin_o[offset*8 +: 8] <= data_i;
                    end
                end
                default: ;   // read-only or unmapped
            endcase
        end
    end

    // read mux, unmapped reads give 0
    always_comb begin
        rdata = 8'h00;
        case (page)
            PAGE_VOL:
                if (int'(offset) < VOL_BYTES) rdata = vol_o[offset*8 +: 8];
            PAGE_NKMD_RST:
                if (offset == 8'd0) rdata = {7'd0, nkmd_rst_o};
            PAGE_DBGOUT:
                if (int'(offset) < DBG_BYTES) rdata = nkmd_dbgout_i[offset*8 +: 8];
            PAGE_DBGIN:
                if (int'(offset) < DBG_BYTES) rdata = nkmd_dbgin_o[offset*8 +: 8];
            PAGE_RATE:
                if (int'(offset) < NUM_SPDIF_IN) begin
                    rdata = 8'(rate_i[offset*NUM_RATE +: NUM_RATE]);
                end
            PAGE_UDATA:
                if (int'(offset) < CAP_BYTES) rdata = udata_i[offset*8 +: 8];
            PAGE_CDATA:
                if (int'(offset) < CAP_BYTES) rdata = cdata_i[offset*8 +: 8];
            default: rdata = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        data_o <= rdata;
    end

    // host must stay inside the gain table
    a_vol_offset: assert property (@(posedge clk) disable iff (rst)
        (ack_i && page == PAGE_VOL) |-> (int'(offset) < VOL_BYTES));

endmodule

`default_nettype wire

// ==== hw/spdif_status_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module spdif_status_capture #(
    parameter int NUM_SPDIF_IN = 3,
    parameter int unsigned CLK_HZ = 24576000
) (
    input  wire clk,
    input  wire rst,

    // already decoded frames, one strobe per frame
    input  wire [NUM_SPDIF_IN-1:0] frame_i,
    input  wire [NUM_SPDIF_IN-1:0] ublk_i,   // frame 0 of a block
    input  wire [NUM_SPDIF_IN-1:0] ubit_i,
    input  wire [NUM_SPDIF_IN-1:0] cbit_i,

    output logic [NUM_SPDIF_IN*audio_pkg::NUM_RATE-1:0] rate_o,
    output logic [NUM_SPDIF_IN*192-1:0] udata_o,
    output logic [NUM_SPDIF_IN*192-1:0] cdata_o
);
    import audio_pkg::*;

    // slowest rate has the longest window
    localparam rate_win_t WIN_SLOW = rate_window(CLK_HZ, 0);
    localparam int CNT_W = $clog2(WIN_SLOW.hi + 1) + 1;
    localparam logic [7:0] LAST_FRAME = 8'd191;

    genvar k, r;
    generate
        for (k = 0; k < NUM_SPDIF_IN; k++) begin : g_in
            logic [CNT_W-1:0] cnt_q;     // cycles since last strobe
            logic [7:0] idx_q;           // next frame slot
            logic [7:0] idx_use;
            logic [NUM_RATE-1:0] in_win;
            logic [NUM_RATE-1:0] rate_q;
            logic [191:0] u_q;
            logic [191:0] c_q;

            // block start wins over the running index
            assign idx_use = ublk_i[k] ? 8'd0 : idx_q;

            for (r = 0; r < NUM_RATE; r++) begin : g_win
                localparam rate_win_t W = rate_window(CLK_HZ, r);
                localparam logic [CNT_W-1:0] LO = CNT_W'(W.lo);
                localparam logic [CNT_W-1:0] HI = CNT_W'(W.hi);

                assign in_win[r] = (cnt_q >= LO) && (cnt_q <= HI);
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    cnt_q <= '1;   // saturated, so first strobe gives rate 0
                    idx_q <= 8'd0;
                    rate_q <= '0;
                    u_q <= '0;
                    c_q <= '0;
                end else if (frame_i[k]) begin
                    cnt_q <= CNT_W'(1);
                    rate_q <= in_win;
                    u_q[idx_use] <= ubit_i[k];
                    c_q[idx_use] <= cbit_i[k];
                    idx_q <= (idx_use == LAST_FRAME) ? 8'd0 : idx_use + 8'd1;
                end else if (cnt_q != '1) begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end

            assign rate_o[k*NUM_RATE +: NUM_RATE] = rate_q;
            assign udata_o[k*192 +: 192] = u_q;
            assign cdata_o[k*192 +: 192] = c_q;

            a_idx_range: assert property (@(posedge clk) disable iff (rst)
                idx_q <= LAST_FRAME);
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hw/sample_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sample_fifo #(
    parameter int FIFO_DEPTH = 8   // power of two
) (
    input  wire clk,
    input  wire rst,

    input  wire push_i,
    input  wire [audio_pkg::CH_BITS_MAX-1:0] ch_i,
    input  wire signed [audio_pkg::SAMPLE_W-1:0] l_i,
    input  wire signed [audio_pkg::SAMPLE_W-1:0] r_i,
    input  wire pop_i,

    output logic empty_o,
    output logic full_o,
    output logic ovf_o,   // sticky, push while full
    output logic [audio_pkg::CH_BITS_MAX-1:0] ch_o,
    output logic signed [audio_pkg::SAMPLE_W-1:0] l_o,
    output logic signed [audio_pkg::SAMPLE_W-1:0] r_o
);
    import audio_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [CH_BITS_MAX-1:0] ch_mem [FIFO_DEPTH];
    logic signed [SAMPLE_W-1:0] l_mem [FIFO_DEPTH];
    logic signed [SAMPLE_W-1:0] r_mem [FIFO_DEPTH];
    logic [AW:0] wp_q;   // extra msb tells full from empty
    logic [AW:0] rp_q;

    assign empty_o = (wp_q == rp_q);
    assign full_o = (wp_q[AW] != rp_q[AW]) && (wp_q[AW-1:0] == rp_q[AW-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            wp_q <= '0;
            rp_q <= '0;
            ovf_o <= 1'b0;
        end else begin
            if (push_i && !full_o) wp_q <= wp_q + 1'b1;
            if (push_i && full_o) ovf_o <= 1'b1;   // item dropped
            if (pop_i && !empty_o) rp_q <= rp_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && !full_o) begin
            ch_mem[wp_q[AW-1:0]] <= ch_i;
            l_mem[wp_q[AW-1:0]] <= l_i;
            r_mem[wp_q[AW-1:0]] <= r_i;
        end
    end

    // fall-through read port
    assign ch_o = ch_mem[rp_q[AW-1:0]];
    assign l_o = l_mem[rp_q[AW-1:0]];
    assign r_o = r_mem[rp_q[AW-1:0]];

    // consumer only pops when something is there
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        !(pop_i && empty_o));

endmodule

`default_nettype wire

// ==== hw/volume_scaler.sv ====
`timescale 1ns/100ps
`default_nettype none

module volume_scaler #(
    parameter int NUM_CH = 8
) (
    input  wire clk,
    input  wire rst,

    input  wire [NUM_CH*32-1:0] vol_i,   // {r, l} gain pair per channel
    input  wire empty_i,
    input  wire [audio_pkg::CH_BITS_MAX-1:0] ch_i,
    input  wire signed [audio_pkg::SAMPLE_W-1:0] l_i,
    input  wire signed [audio_pkg::SAMPLE_W-1:0] r_i,

    output logic pop_o,
    output logic out_valid_o,
    output logic [audio_pkg::CH_BITS_MAX-1:0] out_ch_o,
    output logic signed [audio_pkg::SAMPLE_W-1:0] out_l_o,
    output logic signed [audio_pkg::SAMPLE_W-1:0] out_r_o
);
    import audio_pkg::*;

    localparam int PROD_W = SAMPLE_W + GAIN_W + 1;
    localparam logic signed [SAMPLE_W-1:0] S_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] S_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    scaler_state_e state_q;
    logic [CH_BITS_MAX-1:0] ch_q;
    logic signed [SAMPLE_W-1:0] l_q;
    logic signed [SAMPLE_W-1:0] r_q;
    logic signed [SAMPLE_W-1:0] mul_a;
    logic [GAIN_W-1:0] mul_g;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] shifted;
    logic signed [SAMPLE_W-1:0] sat;

    assign pop_o = (state_q == SC_IDLE) && !empty_i;

    // one multiplier, left half then right half
    assign mul_a = (state_q == SC_LEFT) ? l_q : r_q;
    assign mul_g = (state_q == SC_LEFT) ? vol_i[ch_q*32 +: GAIN_W]
                                        : vol_i[ch_q*32 + 16 +: GAIN_W];
    assign prod = mul_a * $signed({1'b0, mul_g});
    assign shifted = prod >>> GAIN_FRAC;

    // clip to 24 bit when the upper bits are not a plain sign extension
    always_comb begin
        if (&shifted[PROD_W-1:SAMPLE_W-1] || ~|shifted[PROD_W-1:SAMPLE_W-1]) begin
            sat = shifted[SAMPLE_W-1:0];
        end else begin
            sat = shifted[PROD_W-1] ? S_MIN : S_MAX;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= SC_IDLE;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= (state_q == SC_RIGHT);   // both halves done
            case (state_q)
                SC_IDLE:  if (pop_o) state_q <= SC_LEFT;
                SC_LEFT:  state_q <= SC_RIGHT;
                default:  state_q <= SC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            ch_q <= ch_i;
            l_q <= l_i;
            r_q <= r_i;
        end
        if (state_q == SC_LEFT) out_l_o <= sat;
        if (state_q == SC_RIGHT) out_r_o <= sat;
    end

    assign out_ch_o = ch_q;   // held until the next pop lands

endmodule

`default_nettype wire

// ==== hw/audio_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module audio_ctrl_top #(
    parameter int NUM_CH = 8,
    parameter int NUM_SPDIF_IN = 3,
    parameter int unsigned CLK_HZ = 24576000,
    parameter int FIFO_DEPTH = 8
) (
    input  wire clk,
    input  wire rst,

    // host register bus
    input  wire [11:0] addr_i,
    input  wire ack_i,
    input  wire [7:0] data_i,
    output logic [7:0] data_o,

    // dsp core
    output logic nkmd_rst_o,
    input  wire [127:0] nkmd_dbgout_i,
    output logic [127:0] nkmd_dbgin_o,

    // decoded s/pdif frames
    input  wire [NUM_SPDIF_IN-1:0] frame_i,
    input  wire [NUM_SPDIF_IN-1:0] ublk_i,
    input  wire [NUM_SPDIF_IN-1:0] ubit_i,
    input  wire [NUM_SPDIF_IN-1:0] cbit_i,

    // sample input
    input  wire smp_push_i,
    input  wire [audio_pkg::CH_BITS_MAX-1:0] smp_ch_i,
    input  wire signed [audio_pkg::SAMPLE_W-1:0] smp_l_i,
    input  wire signed [audio_pkg::SAMPLE_W-1:0] smp_r_i,
    output logic smp_full_o,
    output logic smp_ovf_o,

    // scaled output
    output logic out_valid_o,
    output logic [audio_pkg::CH_BITS_MAX-1:0] out_ch_o,
    output logic signed [audio_pkg::SAMPLE_W-1:0] out_l_o,
    output logic signed [audio_pkg::SAMPLE_W-1:0] out_r_o
);
    import audio_pkg::*;

    logic [NUM_CH*32-1:0] vol;
    logic [NUM_SPDIF_IN*NUM_RATE-1:0] rate;
    logic [NUM_SPDIF_IN*192-1:0] udata;
    logic [NUM_SPDIF_IN*192-1:0] cdata;
    logic fifo_empty;
    logic fifo_pop;
    logic [CH_BITS_MAX-1:0] fifo_ch;
    logic signed [SAMPLE_W-1:0] fifo_l;
    logic signed [SAMPLE_W-1:0] fifo_r;

    csr #(.NUM_CH(NUM_CH), .NUM_SPDIF_IN(NUM_SPDIF_IN)) csr_i (
        .clk(clk), .rst(rst),
        .addr_i(addr_i), .ack_i(ack_i), .data_i(data_i), .data_o(data_o),
        .vol_o(vol), .nkmd_rst_o(nkmd_rst_o),
        .nkmd_dbgout_i(nkmd_dbgout_i), .nkmd_dbgin_o(nkmd_dbgin_o),
        .rate_i(rate), .udata_i(udata), .cdata_i(cdata)
    );

    spdif_status_capture #(.NUM_SPDIF_IN(NUM_SPDIF_IN), .CLK_HZ(CLK_HZ)) spdif_i (
        .clk(clk), .rst(rst),
        .frame_i(frame_i), .ublk_i(ublk_i), .ubit_i(ubit_i), .cbit_i(cbit_i),
        .rate_o(rate), .udata_o(udata), .cdata_o(cdata)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .clk(clk), .rst(rst),
        .push_i(smp_push_i), .ch_i(smp_ch_i), .l_i(smp_l_i), .r_i(smp_r_i),
        .pop_i(fifo_pop),
        .empty_o(fifo_empty), .full_o(smp_full_o), .ovf_o(smp_ovf_o),
        .ch_o(fifo_ch), .l_o(fifo_l), .r_o(fifo_r)
    );

    volume_scaler #(.NUM_CH(NUM_CH)) scaler_i (
        .clk(clk), .rst(rst),
        .vol_i(vol), .empty_i(fifo_empty),
        .ch_i(fifo_ch), .l_i(fifo_l), .r_i(fifo_r),
        .pop_o(fifo_pop), .out_valid_o(out_valid_o),
        .out_ch_o(out_ch_o), .out_l_o(out_l_o), .out_r_o(out_r_o)
    );

endmodule

`default_nettype wire

// ==== verif/tb_audio_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_audio_ctrl;

    localparam int NUM_CH = 8;
    localparam int NUM_SPDIF_IN = 3;
    localparam int unsigned CLK_HZ = 24576000;
    localparam int FIFO_DEPTH = 8;
    localparam longint RATE_HZ [5] = '{32000, 44100, 48000, 96000, 192000};
    // reset, reset reads, registers, rate, capture, scaling, overflow
    localparam int PHASE_CYCLES = 8 + 200 + 370 + 2700 + 1320 + 420 + 80;
    localparam int MAX_CYCLES = 2 * PHASE_CYCLES;

    logic clk;
    logic rst;
    logic [11:0] addr;
    logic ack;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic nkmd_rst;
    logic [127:0] dbgout;
    logic [127:0] dbgin;
    logic [NUM_SPDIF_IN-1:0] frame;
    logic [NUM_SPDIF_IN-1:0] ublk;
    logic [NUM_SPDIF_IN-1:0] ubit;
    logic [NUM_SPDIF_IN-1:0] cbit;
    logic smp_push;
    logic [2:0] smp_ch;
    logic signed [23:0] smp_l;
    logic signed [23:0] smp_r;
    logic smp_full;
    logic smp_ovf;
    logic out_valid;
    logic [2:0] out_ch;
    logic signed [23:0] out_l;
    logic signed [23:0] out_r;

    // register and capture models
    logic [7:0] vol_m [NUM_CH*4];
    logic rst_m;
    logic [7:0] dbgin_m [16];
    logic [7:0] dbgout_m [16];
    logic [4:0] rate_m [NUM_SPDIF_IN];
    bit u_m [NUM_SPDIF_IN][192];
    bit c_m [NUM_SPDIF_IN][192];
    int idx_m [NUM_SPDIF_IN];
    int last_m [NUM_SPDIF_IN];   // cycle of previous strobe
    bit seen_m [NUM_SPDIF_IN];

    // sample path model
    logic [50:0] exp_q [$];      // {ch, l, r}
    logic [50:0] out_item;
    int m_cnt;
    int m_st;                    // 0 idle, 1 left, 2 right
    bit m_ovf;
    bit m_vld;
    bit m_pop;
    bit m_acc;

    int seed;
    int cyc;
    int errors;
    int checks;

    audio_ctrl_top #(
        .NUM_CH(NUM_CH), .NUM_SPDIF_IN(NUM_SPDIF_IN), .CLK_HZ(CLK_HZ), .FIFO_DEPTH(FIFO_DEPTH)
    ) audio_ctrl_top_i (
        .clk(clk), .rst(rst),
        .addr_i(addr), .ack_i(ack), .data_i(wdata), .data_o(rdata),
        .nkmd_rst_o(nkmd_rst), .nkmd_dbgout_i(dbgout), .nkmd_dbgin_o(dbgin),
        .frame_i(frame), .ublk_i(ublk), .ubit_i(ubit), .cbit_i(cbit),
        .smp_push_i(smp_push), .smp_ch_i(smp_ch), .smp_l_i(smp_l), .smp_r_i(smp_r),
        .smp_full_o(smp_full), .smp_ovf_o(smp_ovf),
        .out_valid_o(out_valid), .out_ch_o(out_ch), .out_l_o(out_l), .out_r_o(out_r)
    );

    always #20 clk = ~clk;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // (sample * gain) >>> 8, clipped to 24 bit
    function automatic logic [23:0] scale(input logic signed [23:0] s, input logic [15:0] g);
        longint p;
        p = (longint'(s) * longint'(g)) >>> 8;
        if (p > 8388607) return 24'h7fffff;
        if (p < -8388608) return 24'h800000;
        return p[23:0];
    endfunction

    function automatic logic [15:0] gain(input int ch, input int half);
        return {vol_m[4*ch + 2*half + 1], vol_m[4*ch + 2*half]};
    endfunction

    function automatic logic [4:0] rate_code(input longint period);
        logic [4:0] code;
        longint clk_hz;
        code = '0;
        clk_hz = CLK_HZ;
        for (int r = 0; r < 5; r++) begin
            if (period >= clk_hz * 97 / (RATE_HZ[r] * 100) &&
                period <= clk_hz * 103 / (RATE_HZ[r] * 100)) code[r] = 1'b1;
        end
        return code;
    endfunction

    // bit b of input k lives in byte 24k + b/8
    function automatic logic [7:0] cap_byte(input bit sel_c, input int off);
        logic [7:0] v;
        int k;
        int b;
        k = off / 24;
        b = off % 24;
        for (int j = 0; j < 8; j++) v[j] = sel_c ? c_m[k][b*8 + j] : u_m[k][b*8 + j];
        return v;
    endfunction

    function automatic logic [7:0] expected_read(input logic [11:0] a);
        logic [7:0] v;
        int off;
        off = a[7:0];
        v = 8'h00;
        case (a[11:8])
            4'h0: if (off < NUM_CH*4) v = vol_m[off];
            4'h4: if (off == 0) v = {7'd0, rst_m};
            4'h5: if (off < 16) v = dbgout_m[off];
            4'h6: if (off < 16) v = dbgin_m[off];
            4'h8: if (off < NUM_SPDIF_IN) v = {3'd0, rate_m[off]};
            4'h9: if (off < NUM_SPDIF_IN*24) v = cap_byte(1'b0, off);
            4'ha: if (off < NUM_SPDIF_IN*24) v = cap_byte(1'b1, off);
            default: v = 8'h00;
        endcase
        return v;
    endfunction

    task automatic log_mismatch(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        errors++;
        $display("[ERROR] %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    endtask

    task automatic write_reg(input logic [11:0] a, input logic [7:0] d);
        addr = a;
        wdata = d;
        ack = 1'b1;
        case (a[11:8])
            4'h0: if (a[7:0] < NUM_CH*4) vol_m[a[7:0]] = d;
            4'h4: if (a[7:0] == 0) rst_m = d[0];
            4'h6: if (a[7:0] < 16) dbgin_m[a[7:0]] = d;
            default: ;   // read only or unmapped
        endcase
        @(negedge clk);
        ack = 1'b0;
    endtask

    task automatic check_read(input logic [11:0] a);
        logic [7:0] exp;
        exp = expected_read(a);
        addr = a;
        ack = 1'b0;
        @(negedge clk);   // data_o registered on the edge in between
        checks++;
        if (rdata !== exp) log_mismatch($sformatf("read 0x%03h", a), rdata, exp);
    endtask

    task automatic check_ports();
        checks++;
        if (nkmd_rst !== rst_m) log_mismatch("nkmd_rst_o", nkmd_rst, rst_m);
        for (int i = 0; i < 16; i++) begin
            if (dbgin[i*8 +: 8] !== dbgin_m[i]) begin
                log_mismatch($sformatf("nkmd_dbgin_o byte %0d", i), dbgin[i*8 +: 8], dbgin_m[i]);
            end
        end
    endtask

    task automatic send_frame(input int k, input bit blk);
        bit u;
        bit c;
        u = rand_below(2);
        c = rand_below(2);
        frame[k] = 1'b1;
        ublk[k] = blk;
        ubit[k] = u;
        cbit[k] = c;
        rate_m[k] = seen_m[k] ? rate_code(cyc - last_m[k]) : 5'd0;
        last_m[k] = cyc;
        seen_m[k] = 1'b1;
        if (blk) idx_m[k] = 0;
        u_m[k][idx_m[k]] = u;
        c_m[k][idx_m[k]] = c;
        idx_m[k] = (idx_m[k] == 191) ? 0 : idx_m[k] + 1;
        @(negedge clk);
        frame = '0;
        ublk = '0;
        ubit = '0;
        cbit = '0;
    endtask

    task automatic wait_until(input int target);
        while (cyc < target) @(negedge clk);
    endtask

    task automatic push_sample();
        smp_push = 1'b1;
        smp_ch = 3'(rand_below(NUM_CH));
        case (rand_below(4))
            0: begin
                smp_l = 24'h7fffff;
                smp_r = 24'h800000;
            end
            1: begin
                smp_l = 24'h800000;
                smp_r = 24'h7fffff;
            end
            default: begin
                smp_l = 24'($random(seed));
                smp_r = 24'($random(seed));
            end
        endcase
        @(negedge clk);
        smp_push = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || m_cnt != 0 || m_st != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    // fifo occupancy and scaler slot model, 3 cycles per item
    always @(posedge clk) begin
        if (rst) begin
            m_cnt = 0;
            m_st = 0;
            m_ovf = 1'b0;
            m_vld = 1'b0;
        end else begin
            m_vld = (m_st == 2);
            m_pop = (m_st == 0) && (m_cnt != 0);
            m_acc = smp_push && (m_cnt < FIFO_DEPTH);
            if (smp_push && !m_acc) m_ovf = 1'b1;   // dropped
            if (m_acc) begin
                exp_q.push_back({smp_ch, scale(smp_l, gain(smp_ch, 0)),
                                 scale(smp_r, gain(smp_ch, 1))});
            end
            m_cnt = m_cnt + int'(m_acc) - int'(m_pop);
            m_st = m_pop ? 1 : (m_st == 1) ? 2 : 0;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (smp_full !== (m_cnt == FIFO_DEPTH)) begin
                log_mismatch("smp_full_o", smp_full, m_cnt == FIFO_DEPTH);
            end
            if (smp_ovf !== m_ovf) log_mismatch("smp_ovf_o", smp_ovf, m_ovf);
            if (out_valid !== m_vld) log_mismatch("out_valid_o", out_valid, m_vld);
            if (out_valid === 1'b1) begin
                checks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("[ERROR] %0t ns: output sample with nothing pending", $time);
                end else begin
                    out_item = exp_q.pop_front();
                    if (out_ch !== out_item[50:48]) log_mismatch("out_ch_o", out_ch, out_item[50:48]);
                    if (out_l !== out_item[47:24]) log_mismatch("out_l_o", out_l, out_item[47:24]);
                    if (out_r !== out_item[23:0]) log_mismatch("out_r_o", out_r, out_item[23:0]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int r;
        longint period;
        bit seen_full;
        seed = 31;
        cyc = 0;
        errors = 0;
        checks = 0;
        clk = 1'b0;
        rst = 1'b1;
        addr = '0;
        ack = 1'b0;
        wdata = '0;
        dbgout = '0;
        frame = '0;
        ublk = '0;
        ubit = '0;
        cbit = '0;
        smp_push = 1'b0;
        smp_ch = '0;
        smp_l = '0;
        smp_r = '0;
        for (int i = 0; i < NUM_CH*4; i++) vol_m[i] = (i % 2 == 0) ? 8'hff : 8'h00;
        for (int i = 0; i < 16; i++) dbgin_m[i] = 8'h00;
        for (int i = 0; i < 16; i++) dbgout_m[i] = 8'h00;
        for (int k = 0; k < NUM_SPDIF_IN; k++) rate_m[k] = 5'd0;
        rst_m = 1'b1;   // dsp starts held in reset
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // reset values
        check_ports();
        for (int a = 0; a < NUM_CH*4; a++) check_read({4'h0, 8'(a)});
        check_read(12'h400);
        for (int a = 0; a < 16; a++) check_read({4'h6, 8'(a)});
        for (int a = 0; a < NUM_SPDIF_IN; a++) check_read({4'h8, 8'(a)});
        for (int a = 0; a < NUM_SPDIF_IN*24; a++) check_read({4'h9, 8'(a)});
        for (int a = 0; a < NUM_SPDIF_IN*24; a++) check_read({4'ha, 8'(a)});

        // random register traffic, gain page kept inside the table
        for (int i = 0; i < 16; i++) begin
            dbgout_m[i] = 8'($random(seed));
            dbgout[i*8 +: 8] = dbgout_m[i];
        end
        for (int i = 0; i < 150; i++) begin
            case (rand_below(4))
                0: write_reg({4'h0, 8'(rand_below(NUM_CH*4))}, 8'($random(seed)));
                1: write_reg({4'h4, 8'(rand_below(4))}, 8'($random(seed)));
                2: write_reg({4'h6, 8'(rand_below(20))}, 8'($random(seed)));
                default: write_reg({4'(1 + rand_below(15)), 8'(rand_below(256))},
                                   8'($random(seed)));
            endcase
            check_ports();
            check_read({4'(rand_below(16)), 8'(rand_below(48))});
        end
        for (int a = 0; a < NUM_CH*4; a++) check_read({4'h0, 8'(a)});
        check_read(12'h400);
        for (int a = 0; a < 16; a++) check_read({4'h5, 8'(a)});
        for (int a = 0; a < 16; a++) check_read({4'h6, 8'(a)});

        // rate: first strobe, nominal period, then too short a period
        for (int k = 0; k < NUM_SPDIF_IN; k++) begin
            send_frame(k, 1'b0);
            check_read({4'h8, 8'(k)});
            r = rand_below(5);
            period = CLK_HZ / RATE_HZ[r];
            wait_until(last_m[k] + int'(period));
            send_frame(k, 1'b0);
            check_read({4'h8, 8'(k)});
            wait_until(last_m[k] + 100 + rand_below(20));
            send_frame(k, 1'b0);
            check_read({4'h8, 8'(k)});
        end

        // one full block per input plus two frames past the wrap
        for (int k = 0; k < NUM_SPDIF_IN; k++) begin
            for (int i = 0; i < 194; i++) begin
                send_frame(k, i == 0);
                @(negedge clk);
            end
        end
        for (int a = 0; a < NUM_SPDIF_IN*24 + 4; a++) check_read({4'h9, 8'(a)});
        for (int a = 0; a < NUM_SPDIF_IN*24 + 4; a++) check_read({4'ha, 8'(a)});
        for (int a = 0; a < NUM_SPDIF_IN; a++) check_read({4'h8, 8'(a)});

        // volume scaling at a pace the scaler keeps up with
        for (int a = 0; a < NUM_CH*4; a++) begin
            if (a % 2 == 1 && rand_below(3) == 0) write_reg({4'h0, 8'(a)}, 8'h01);
            else write_reg({4'h0, 8'(a)}, 8'($random(seed)));
        end
        for (int i = 0; i < 60; i++) begin
            push_sample();
            repeat (2 + rand_below(4)) @(negedge clk);
        end
        drain();
        checks++;
        if (smp_ovf !== 1'b0) log_mismatch("smp_ovf_o after paced pushes", smp_ovf, 0);

        // overflow, one push every cycle
        seen_full = 1'b0;
        for (int i = 0; i < 40; i++) begin
            push_sample();
            if (smp_full === 1'b1) seen_full = 1'b1;
        end
        drain();
        checks++;
        if (!seen_full) begin
            errors++;
            $display("[ERROR] %0t ns: smp_full_o never rose while pushing every cycle", $time);
        end
        if (smp_ovf !== 1'b1) log_mismatch("smp_ovf_o after overflow", smp_ovf, 1);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/audio_pkg.sv
hw/csr.sv
hw/spdif_status_capture.sv
hw/sample_fifo.sv
hw/volume_scaler.sv
hw/audio_ctrl_top.sv
verif/tb_audio_ctrl.sv

// ==== Makefile ====
TOP := tb_audio_ctrl
SRCS := $(shell grep -v '^+' verilog.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
